/* rtl/branch_resolve.sv */
`default_nettype none

module branch_resolve
    import mips_id_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      accept_i,
    input  word_t     pc_i,
    input  dec_ctrl_t ctrl_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    output logic      taken_o,
    output word_t     target_o,
    output word_t     link_addr_o,
    output logic      in_delayslot_o
);

    word_t pc_plus_4;
    word_t rel_target;
    logic  reg1_neg;
    logic  reg1_zero;
    logic  delay_q;

    assign pc_plus_4  = pc_i + 32'd4;
    assign rel_target = pc_plus_4 + {ctrl_i.imm[29:0], 2'b00};
    assign reg1_neg   = reg1_i[31];
    assign reg1_zero  = (reg1_i == '0);

    always_comb begin
        taken_o  = 1'b0;
        target_o = rel_target;
        case (ctrl_i.jump_kind)
            J_ABS: begin
                taken_o  = 1'b1;
                target_o = ctrl_i.imm;   // already absolute from decode
            end
            J_REG: begin
                taken_o  = 1'b1;
                target_o = reg1_i;
            end
            BR_EQ:   taken_o = (reg1_i == reg2_i);
            BR_NE:   taken_o = (reg1_i != reg2_i);
            BR_GTZ:  taken_o = !reg1_neg && !reg1_zero;
            BR_LEZ:  taken_o = reg1_neg || reg1_zero;
            BR_GEZ:  taken_o = !reg1_neg;
            BR_LTZ:  taken_o = reg1_neg;
            default: target_o = '0;
        endcase
    end

    assign link_addr_o = ctrl_i.link ? (pc_i + 32'd8) : '0;

    // next accepted instruction sits in the delay slot
    always_ff @(posedge clk) begin
        if (rst_i) begin
            delay_q <= 1'b0;
        end else if (accept_i) begin
            delay_q <= taken_o;
        end
    end

    assign in_delayslot_o = delay_q;

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`default_nettype none

module id_stage
    import mips_id_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  fetch_pkt_t fetch_i,
    input  logic       fetch_valid_i,
    output logic       fetch_ready_o,
    input  wr_port_t   ex_wr_i,
    input  wr_port_t   mem_wr_i,
    input  wr_port_t   wb_wr_i,
    output id_pkt_t    id_pkt_o,
    output logic       id_valid_o,
    input  logic       id_ready_i
);

    dec_ctrl_t ctrl;
    word_t     rd1_data;
    word_t     rd2_data;
    word_t     reg1;
    word_t     reg2;
    logic      taken;
    word_t     target;
    word_t     link_addr;
    logic      in_delayslot;
    logic      accept;
    id_pkt_t   pkt_d;

    assign fetch_ready_o = !id_valid_o || id_ready_i;
    assign accept        = fetch_valid_i && fetch_ready_o;

    inst_decoder i_decoder (
        .inst_i (fetch_i.inst),
        .pc_i   (fetch_i.pc),
        .ctrl_o (ctrl)
    );

    regfile i_regfile (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_i       (wb_wr_i),
        .rd1_addr_i (ctrl.rd1_addr),
        .rd2_addr_i (ctrl.rd2_addr),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data)
    );

    operand_select i_op1_sel (
        .rd_en_i   (ctrl.rd1_en),
        .rd_addr_i (ctrl.rd1_addr),
        .rf_data_i (rd1_data),
        .imm_i     (ctrl.imm),
        .ex_wr_i   (ex_wr_i),
        .mem_wr_i  (mem_wr_i),
        .operand_o (reg1)
    );

    operand_select i_op2_sel (
        .rd_en_i   (ctrl.rd2_en),
        .rd_addr_i (ctrl.rd2_addr),
        .rf_data_i (rd2_data),
        .imm_i     (ctrl.imm),
        .ex_wr_i   (ex_wr_i),
        .mem_wr_i  (mem_wr_i),
        .operand_o (reg2)
    );

    branch_resolve i_branch (
        .clk            (clk),
        .rst_i          (rst_i),
        .accept_i       (accept),
        .pc_i           (fetch_i.pc),
        .ctrl_i         (ctrl),
        .reg1_i         (reg1),
        .reg2_i         (reg2),
        .taken_o        (taken),
        .target_o       (target),
        .link_addr_o    (link_addr),
        .in_delayslot_o (in_delayslot)
    );

    always_comb begin
        pkt_d.aluop           = ctrl.aluop;
        pkt_d.alusel          = ctrl.alusel;
        pkt_d.reg1            = reg1;
        pkt_d.reg2            = reg2;
        pkt_d.wd              = ctrl.wd;
        pkt_d.wreg            = ctrl.wreg;
        pkt_d.link_addr       = link_addr;
        pkt_d.branch_taken    = taken;
        pkt_d.branch_target   = taken ? target : '0;   // not taken carries zero
        pkt_d.is_in_delayslot = in_delayslot;
        pkt_d.inst_valid      = ctrl.inst_valid;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_valid_o <= 1'b0;
        end else if (accept) begin
            id_valid_o <= 1'b1;
        end else if (id_ready_i) begin
            id_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_pkt_o <= pkt_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`default_nettype none

module inst_decoder
    import mips_id_pkg::*;
(
    input  inst_t     inst_i,
    input  word_t     pc_i,
    output dec_ctrl_t ctrl_o
);

    logic [5:0] op;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    word_t      imm_zx;
    word_t      imm_sx;
    word_t      pc_plus_4;
    dec_ctrl_t  dec;

    assign op     = inst_i[OP_MSB:OP_LSB];
    assign funct  = inst_i[FN_MSB:FN_LSB];
    assign rs     = inst_i[RS_MSB:RS_LSB];
    assign rt     = inst_i[RT_MSB:RT_LSB];
    assign rd     = inst_i[RD_MSB:RD_LSB];
    assign shamt  = inst_i[SH_MSB:SH_LSB];
    assign imm_zx = {16'h0, inst_i[IMM_MSB:IMM_LSB]};
    assign imm_sx = {{16{inst_i[IMM_MSB]}}, inst_i[IMM_MSB:IMM_LSB]};
    assign pc_plus_4 = pc_i + 32'd4;

    function automatic dec_ctrl_t set_op(dec_ctrl_t c, aluop_e aop, alusel_e sel);
        dec_ctrl_t r;
        r = c;
        r.aluop  = aop;
        r.alusel = sel;
        return r;
    endfunction

    always_comb begin
        dec = DEC_NOP;
        dec.rd1_addr = rs;
        dec.rd2_addr = rt;
        case (op)
            OP_SPECIAL: begin
                dec.rd1_en     = 1'b1;
                dec.rd2_en     = 1'b1;
                dec.wd         = rd;
                dec.wreg       = 1'b1;
                dec.inst_valid = (shamt == '0);
                case (funct)
                    FN_OR:   dec = set_op(dec, ALU_OR, SEL_LOGIC);
                    FN_AND:  dec = set_op(dec, ALU_AND, SEL_LOGIC);
                    FN_XOR:  dec = set_op(dec, ALU_XOR, SEL_LOGIC);
                    FN_NOR:  dec = set_op(dec, ALU_NOR, SEL_LOGIC);
                    FN_SLL:  dec = set_op(dec, ALU_SLL, SEL_SHIFT);
                    FN_SRL:  dec = set_op(dec, ALU_SRL, SEL_SHIFT);
                    FN_SRA:  dec = set_op(dec, ALU_SRA, SEL_SHIFT);
                    FN_SLLV: dec = set_op(dec, ALU_SLLV, SEL_SHIFT);
                    FN_SRLV: dec = set_op(dec, ALU_SRLV, SEL_SHIFT);
                    FN_SRAV: dec = set_op(dec, ALU_SRAV, SEL_SHIFT);
                    FN_ADD:  dec = set_op(dec, ALU_ADD, SEL_ARITH);
                    FN_ADDU: dec = set_op(dec, ALU_ADDU, SEL_ARITH);
                    FN_SUB:  dec = set_op(dec, ALU_SUB, SEL_ARITH);
                    FN_SUBU: dec = set_op(dec, ALU_SUBU, SEL_ARITH);
                    FN_SLT:  dec = set_op(dec, ALU_SLT, SEL_ARITH);
                    FN_SLTU: dec = set_op(dec, ALU_SLTU, SEL_ARITH);
                    FN_JR:   dec = set_op(dec, ALU_JR, SEL_JUMP_BRANCH);
                    FN_JALR: dec = set_op(dec, ALU_JALR, SEL_JUMP_BRANCH);
                    default: dec.inst_valid = 1'b0;
                endcase
                // shift by shamt: rt in reg2, amount as immediate in reg1
                if (funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
                    dec.rd1_en     = 1'b0;
                    dec.imm        = {27'h0, shamt};
                    dec.inst_valid = (rs == '0);
                end
                if (funct inside {FN_JR, FN_JALR}) begin
                    dec.rd2_en    = 1'b0;
                    dec.jump_kind = J_REG;
                    dec.link      = (funct == FN_JALR);
                    dec.wreg      = (funct == FN_JALR);
                    dec.wd        = (funct == FN_JALR) ? rd : '0;
                end
            end
            OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                dec.rd1_en     = 1'b1;
                dec.wd         = rt;
                dec.wreg       = 1'b1;
                dec.inst_valid = 1'b1;
                dec.imm        = imm_sx;
                case (op)
                    OP_ORI:   dec = set_op(dec, ALU_ORI, SEL_LOGIC);
                    OP_ANDI:  dec = set_op(dec, ALU_ANDI, SEL_LOGIC);
                    OP_XORI:  dec = set_op(dec, ALU_XORI, SEL_LOGIC);
                    OP_LUI:   dec = set_op(dec, ALU_LUI, SEL_LOGIC);
                    OP_ADDI:  dec = set_op(dec, ALU_ADDI, SEL_ARITH);
                    OP_ADDIU: dec = set_op(dec, ALU_ADDIU, SEL_ARITH);
                    OP_SLTI:  dec = set_op(dec, ALU_SLTI, SEL_ARITH);
                    default:  dec = set_op(dec, ALU_SLTIU, SEL_ARITH);
                endcase
                if (op inside {OP_ORI, OP_ANDI, OP_XORI}) begin
                    dec.imm = imm_zx;
                end
                if (op == OP_LUI) begin
                    dec.imm = {inst_i[IMM_MSB:IMM_LSB], 16'h0};
                end
            end
            OP_J, OP_JAL: begin
                dec = set_op(dec, (op == OP_JAL) ? ALU_JAL : ALU_J, SEL_JUMP_BRANCH);
                dec.imm        = {pc_plus_4[31:28], inst_i[TGT_MSB:TGT_LSB], 2'b00};
                dec.jump_kind  = J_ABS;
                dec.link       = (op == OP_JAL);
                dec.wreg       = (op == OP_JAL);
                dec.wd         = (op == OP_JAL) ? LINK_REG : '0;
                dec.inst_valid = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
                dec.rd1_en     = 1'b1;
                dec.rd2_en     = op inside {OP_BEQ, OP_BNE};
                dec.imm        = imm_sx;    // word offset, scaled in branch_resolve
                dec.inst_valid = 1'b1;
                case (op)
                    OP_BEQ: begin
                        dec = set_op(dec, ALU_BEQ, SEL_JUMP_BRANCH);
                        dec.jump_kind = BR_EQ;
                    end
                    OP_BNE: begin
                        dec = set_op(dec, ALU_BNE, SEL_JUMP_BRANCH);
                        dec.jump_kind = BR_NE;
                    end
                    OP_BGTZ: begin
                        dec = set_op(dec, ALU_BGTZ, SEL_JUMP_BRANCH);
                        dec.jump_kind = BR_GTZ;
                    end
                    default: begin
                        dec = set_op(dec, ALU_BLEZ, SEL_JUMP_BRANCH);
                        dec.jump_kind = BR_LEZ;
                    end
                endcase
            end
            OP_REGIMM: begin
                dec.rd1_en     = 1'b1;
                dec.imm        = imm_sx;
                dec.inst_valid = 1'b1;
                dec.link       = rt[4];     // the al forms
                dec.wreg       = rt[4];
                dec.wd         = rt[4] ? LINK_REG : '0;
                dec.jump_kind  = rt[0] ? BR_GEZ : BR_LTZ;
                case (rt)
                    RT_BLTZ:   dec = set_op(dec, ALU_BLTZ, SEL_JUMP_BRANCH);
                    RT_BGEZ:   dec = set_op(dec, ALU_BGEZ, SEL_JUMP_BRANCH);
                    RT_BLTZAL: dec = set_op(dec, ALU_BLTZAL, SEL_JUMP_BRANCH);
                    RT_BGEZAL: dec = set_op(dec, ALU_BGEZAL, SEL_JUMP_BRANCH);
                    default:   dec.inst_valid = 1'b0;
                endcase
            end
            default: dec.inst_valid = 1'b0;
        endcase
    end

    // anything outside the kept set leaves as a clean nop
    assign ctrl_o = dec.inst_valid ? dec : DEC_NOP;

endmodule

`default_nettype wire

/* rtl/mips_id_pkg.sv */
`default_nettype none

package mips_id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int        REG_COUNT = 32;
    localparam reg_addr_t LINK_REG  = 5'd31;   // $ra

    // instruction fields
    localparam int OP_MSB  = 31;
    localparam int OP_LSB  = 26;
    localparam int RS_MSB  = 25;
    localparam int RS_LSB  = 21;
    localparam int RT_MSB  = 20;
    localparam int RT_LSB  = 16;
    localparam int RD_MSB  = 15;
    localparam int RD_LSB  = 11;
    localparam int SH_MSB  = 10;
    localparam int SH_LSB  = 6;
    localparam int FN_MSB  = 5;
    localparam int FN_LSB  = 0;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;
    localparam int TGT_MSB = 25;
    localparam int TGT_LSB = 0;

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // regimm selects in the rt field
    localparam logic [4:0] RT_BLTZ   = 5'b00000;
    localparam logic [4:0] RT_BGEZ   = 5'b00001;
    localparam logic [4:0] RT_BLTZAL = 5'b10000;
    localparam logic [4:0] RT_BGEZAL = 5'b10001;

    typedef enum logic [5:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR, ALU_ORI, ALU_ANDI, ALU_XORI, ALU_LUI,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU,
        ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
        ALU_BGEZ, ALU_BLTZ, ALU_BGEZAL, ALU_BLTZAL
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_JUMP_BRANCH
    } alusel_e;

    typedef enum logic [3:0] {
        NONE, J_ABS, J_REG, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
    } jump_kind_e;

    typedef struct packed {
        word_t pc;
        inst_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wr_port_t;

    typedef struct packed {
        logic       rd1_en;
        reg_addr_t  rd1_addr;
        logic       rd2_en;
        reg_addr_t  rd2_addr;
        word_t      imm;
        aluop_e     aluop;
        alusel_e    alusel;
        reg_addr_t  wd;
        logic       wreg;
        jump_kind_e jump_kind;
        logic       link;
        logic       inst_valid;
    } dec_ctrl_t;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        word_t     link_addr;
        logic      branch_taken;
        word_t     branch_target;
        logic      is_in_delayslot;
        logic      inst_valid;
    } id_pkt_t;

    localparam dec_ctrl_t DEC_NOP = '0;   // all enums encode zero as nop/none

endpackage

`default_nettype wire

/* rtl/operand_select.sv */
`default_nettype none

module operand_select
    import mips_id_pkg::*;
(
    input  logic      rd_en_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     rf_data_i,
    input  word_t     imm_i,
    input  wr_port_t  ex_wr_i,
    input  wr_port_t  mem_wr_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 is never forwarded
    assign ex_hit  = ex_wr_i.we && (ex_wr_i.waddr == rd_addr_i) && (rd_addr_i != '0);
    assign mem_hit = mem_wr_i.we && (mem_wr_i.waddr == rd_addr_i) && (rd_addr_i != '0);

    always_comb begin
        if (!rd_en_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_wr_i.wdata;     // newest result first
        end else if (mem_hit) begin
            operand_o = mem_wr_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`default_nettype none

module regfile
    import mips_id_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  wr_port_t  wr_i,
    input  reg_addr_t rd1_addr_i,
    input  reg_addr_t rd2_addr_i,
    output word_t     rd1_data_o,
    output word_t     rd2_data_o
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.waddr != '0)) begin   // r0 stays zero
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // no write bypass, a same-cycle read sees the old value
    assign rd1_data_o = regs[rd1_addr_i];
    assign rd2_data_o = regs[rd2_addr_i];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the id stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_id_stage -f src.f -o sim_id_stage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_id_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi

/* src.f */
rtl/mips_id_pkg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_select.sv
rtl/branch_resolve.sv
rtl/id_stage.sv
tests/id_checker.sv
tests/tb_id_stage.sv

/* tests/id_checker.sv */
`default_nettype none

module id_checker
    import mips_id_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        fetch_valid_i,
    input  logic        fetch_ready_i,
    input  logic [31:0] exp_test_i,
    input  id_pkt_t     exp_pkt_i,
    input  id_pkt_t     id_pkt_i,
    input  logic        id_valid_i,
    input  logic        id_ready_i,
    output int          pass_cnt_o,
    output int          fail_cnt_o,
    output int          pending_o,
    output int          stray_cnt_o,
    output int          ready_err_cnt_o
);

    id_pkt_t exp_q [$];
    int      test_q [$];

    initial begin
        pass_cnt_o      = 0;
        fail_cnt_o      = 0;
        pending_o       = 0;
        stray_cnt_o     = 0;
        ready_err_cnt_o = 0;
    end

    function automatic int field_diff(int test_no, string name, logic [31:0] got,
                                      logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: test %0d field %s got %h expected %h",
                     $time, test_no, name, got, exp);
            return 1;
        end
        return 0;
    endfunction

    task automatic compare_packet();
        id_pkt_t exp;
        int      test_no;
        int      bad;
        exp     = exp_q.pop_front();
        test_no = test_q.pop_front();
        bad     = 0;
        bad += field_diff(test_no, "aluop", 32'(id_pkt_i.aluop), 32'(exp.aluop));
        bad += field_diff(test_no, "alusel", 32'(id_pkt_i.alusel), 32'(exp.alusel));
        bad += field_diff(test_no, "reg1", id_pkt_i.reg1, exp.reg1);
        bad += field_diff(test_no, "reg2", id_pkt_i.reg2, exp.reg2);
        bad += field_diff(test_no, "wd", 32'(id_pkt_i.wd), 32'(exp.wd));
        bad += field_diff(test_no, "wreg", 32'(id_pkt_i.wreg), 32'(exp.wreg));
        bad += field_diff(test_no, "link_addr", id_pkt_i.link_addr, exp.link_addr);
        bad += field_diff(test_no, "branch_taken", 32'(id_pkt_i.branch_taken),
                          32'(exp.branch_taken));
        bad += field_diff(test_no, "branch_target", id_pkt_i.branch_target,
                          exp.branch_target);
        bad += field_diff(test_no, "is_in_delayslot", 32'(id_pkt_i.is_in_delayslot),
                          32'(exp.is_in_delayslot));
        bad += field_diff(test_no, "inst_valid", 32'(id_pkt_i.inst_valid),
                          32'(exp.inst_valid));
        if (bad == 0) begin
            pass_cnt_o++;
            $display("test %0d ok", test_no);
        end else begin
            fail_cnt_o++;
            $display("test %0d failed with %0d wrong fields", test_no, bad);
        end
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            if (id_valid_i) begin
                stray_cnt_o++;
                $display("DUT presented a packet during reset at %0t", $time);
            end
        end else begin
            // only a stalled stage refuses input
            if (fetch_ready_i === (id_valid_i && !id_ready_i)) begin
                ready_err_cnt_o++;
                $display("** Error at %0t: fetch_ready %b with id_valid %b id_ready %b",
                         $time, fetch_ready_i, id_valid_i, id_ready_i);
            end
            // the old packet leaves before a new one is queued
            if (id_valid_i && id_ready_i) begin
                if (exp_q.size() == 0) begin
                    stray_cnt_o++;
                    $display("DUT sent an extra packet with nothing expected at %0t", $time);
                end else begin
                    compare_packet();
                end
            end
            if (fetch_valid_i && fetch_ready_i) begin
                exp_q.push_back(exp_pkt_i);
                test_q.push_back(int'(exp_test_i));
            end
        end
        pending_o = exp_q.size();
    end

endmodule

`default_nettype wire

/* tests/id_tests.dat */
# W addr data | I test pc inst ex_we ex_addr ex_data mem_we mem_addr mem_data
# then aluop alusel reg1 reg2 wd wreg link_addr taken target delayslot inst_valid
W 01 00000011
W 02 00000022
W 03 80000000
W 04 00000000
W 00 deadbeef
I 1 00400000 00222825 0 0 0 0 0 0 01 1 00000011 00000022 05 1 00000000 0 00000000 0 1
I 2 00400004 34268001 0 0 0 0 0 0 05 1 00000011 00008001 06 1 00000000 0 00000000 0 1
I 3 00400008 3c071234 0 0 0 0 0 0 08 1 00000000 12340000 07 1 00000000 0 00000000 0 1
I 4 0040000c 00024100 0 0 0 0 0 0 09 2 00000004 00000022 08 1 00000000 0 00000000 0 1
I 5 00400010 00234807 0 0 0 0 0 0 0e 2 00000011 80000000 09 1 00000000 0 00000000 0 1
I 6 00400014 202afffe 0 0 0 0 0 0 15 3 00000011 fffffffe 0a 1 00000000 0 00000000 0 1
I 7 00400018 00415823 0 0 0 0 0 0 12 3 00000022 00000011 0b 1 00000000 0 00000000 0 1
I 8 0040001c 2c6c8000 0 0 0 0 0 0 18 3 80000000 ffff8000 0c 1 00000000 0 00000000 0 1
I 9 00400020 00226820 1 01 aaaaaaaa 1 01 bbbbbbbb 0f 3 aaaaaaaa 00000022 0d 1 0 0 0 0 1
I 10 00400024 00227024 1 05 11111111 1 02 cccccccc 02 1 00000011 cccccccc 0e 1 0 0 0 0 1
I 11 00400028 00017826 1 00 55555555 0 0 0 03 1 00000000 00000011 0f 1 0 0 0 0 1
I 12 00400100 10210004 0 0 0 0 0 0 1d 4 00000011 00000011 00 0 00000000 1 00400114 0 1
I 13 00400104 00228021 0 0 0 0 0 0 10 3 00000011 00000022 10 1 00000000 0 00000000 1 1
I 14 00400108 1421ffff 0 0 0 0 0 0 1e 4 00000011 00000011 00 0 00000000 0 00000000 0 1
I 15 0040010c 00228827 0 0 0 0 0 0 04 1 00000011 00000022 11 1 00000000 0 00000000 0 1
I 16 00400110 1c200002 0 0 0 0 0 0 1f 4 00000011 00000002 00 0 00000000 1 0040011c 0 1
I 17 00400114 1860fffc 0 0 0 0 0 0 20 4 80000000 fffffffc 00 0 00000000 1 00400108 1 1
I 18 00400118 04610010 0 0 0 0 0 0 21 4 80000000 00000010 00 0 00000000 0 00000000 1 1
I 19 0040011c 04700008 0 0 0 0 0 0 24 4 80000000 00000008 1f 1 00400124 1 00400140 0 1
I 20 00400140 04910001 0 0 0 0 0 0 23 4 00000000 00000001 1f 1 00400148 1 00400148 1 1
I 21 00400144 04200003 0 0 0 0 0 0 22 4 00000011 00000003 00 0 00000000 0 00000000 1 1
I 22 00400148 08100080 0 0 0 0 0 0 19 4 00400200 00400200 00 0 00000000 1 00400200 0 1
I 23 00400200 0c1000c0 0 0 0 0 0 0 1a 4 00400300 00400300 1f 1 00400208 1 00400300 1 1
I 24 00400300 00400008 0 0 0 0 0 0 1b 4 00000022 00000000 00 0 00000000 1 00000022 1 1
I 25 00000020 0020f809 0 0 0 0 0 0 1c 4 00000011 00000000 1f 1 00000028 1 00000011 1 1
I 26 00000024 8c220004 0 0 0 0 0 0 00 0 00000000 00000000 00 0 00000000 0 00000000 1 0
I 27 00000028 00220018 0 0 0 0 0 0 00 0 00000000 00000000 00 0 00000000 0 00000000 0 0
I 28 0000002c 3852f0f0 0 0 0 0 0 0 07 1 00000022 0000f0f0 12 1 00000000 0 00000000 0 1

/* tests/tb_id_stage.sv */
`default_nettype none

module tb_id_stage
    import mips_id_pkg::*;
;

    localparam int MAX_REC = 64;

    logic       clk;
    logic       rst_i;
    fetch_pkt_t fetch_i;
    logic       fetch_valid_i;
    logic       fetch_ready_o;
    wr_port_t   ex_wr_i;
    wr_port_t   mem_wr_i;
    wr_port_t   wb_wr_i;
    id_pkt_t    id_pkt_o;
    logic       id_valid_o;
    logic       id_ready_i;

    logic [31:0] exp_test;
    id_pkt_t     exp_pkt;
    int          pass_cnt;
    int          fail_cnt;
    int          pending_cnt;
    int          stray_cnt;
    int          ready_err_cnt;

    logic        rec_write [MAX_REC];
    logic [31:0] rec_test [MAX_REC];
    fetch_pkt_t  rec_fetch [MAX_REC];
    wr_port_t    rec_ex [MAX_REC];
    wr_port_t    rec_mem [MAX_REC];
    id_pkt_t     rec_exp [MAX_REC];
    int          n_rec;
    int          n_inst;
    logic        loaded;
    integer      seed;

    id_stage i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_i       (fetch_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .ex_wr_i       (ex_wr_i),
        .mem_wr_i      (mem_wr_i),
        .wb_wr_i       (wb_wr_i),
        .id_pkt_o      (id_pkt_o),
        .id_valid_o    (id_valid_o),
        .id_ready_i    (id_ready_i)
    );

    id_checker i_checker (
        .clk             (clk),
        .rst_i           (rst_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_ready_i   (fetch_ready_o),
        .exp_test_i      (exp_test),
        .exp_pkt_i       (exp_pkt),
        .id_pkt_i        (id_pkt_o),
        .id_valid_i      (id_valid_o),
        .id_ready_i      (id_ready_i),
        .pass_cnt_o      (pass_cnt),
        .fail_cnt_o      (fail_cnt),
        .pending_o       (pending_cnt),
        .stray_cnt_o     (stray_cnt),
        .ready_err_cnt_o (ready_err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // downstream stalls on about a quarter of the cycles
    initial begin
        seed = 32'h0e6c82c6;
        id_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            id_ready_i = (($random(seed) & 32'h3) != 32'h0);
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = (longint'(n_rec) * 50 + 16) * 40;
        #(limit);
        $display("timeout, the DUT stopped moving packets at %0t", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic read_records(output logic ok);
        int           fd;
        int           rc;
        logic [7:0]   kind;
        logic [31:0]  f [20];
        logic [1023:0] line;
        ok = 1'b0;
        fd = $fopen("tests/id_tests.dat", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd) && n_rec < MAX_REC) begin
                rc = $fscanf(fd, " %c", kind);
                if (rc == 1 && kind == "#") begin
                    rc = $fgets(line, fd);
                end else if (rc == 1 && kind == "W") begin
                    rc = $fscanf(fd, "%h %h", f[0], f[1]);
                    rec_write[n_rec] = 1'b1;
                    rec_ex[n_rec]    = {1'b1, f[0][4:0], f[1]};   // writeback data
                    n_rec++;
                end else if (rc == 1 && kind == "I") begin
                    rc = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                                 f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                                 f[18], f[19]);
                    rec_write[n_rec] = 1'b0;
                    rec_test[n_rec]  = f[0];
                    rec_fetch[n_rec] = {f[1], f[2]};
                    rec_ex[n_rec]    = {f[3][0], f[4][4:0], f[5]};
                    rec_mem[n_rec]   = {f[6][0], f[7][4:0], f[8]};
                    rec_exp[n_rec]   = {f[9][5:0], f[10][2:0], f[11], f[12], f[13][4:0],
                                        f[14][0], f[15], f[16][0], f[17], f[18][0], f[19][0]};
                    n_rec++;
                    n_inst++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_write(int i);
        wb_wr_i = rec_ex[i];
        @(negedge clk);
        wb_wr_i = '0;
    endtask

    task automatic drive_inst(int i);
        logic accepted;
        fetch_i       = rec_fetch[i];
        ex_wr_i       = rec_ex[i];
        mem_wr_i      = rec_mem[i];
        exp_test      = rec_test[i];
        exp_pkt       = rec_exp[i];
        fetch_valid_i = 1'b1;
        accepted      = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = fetch_ready_o;   // pre-edge value
        end
        @(negedge clk);
        fetch_valid_i = 1'b0;
        ex_wr_i       = '0;
        mem_wr_i      = '0;
    endtask

    initial begin
        logic ok;
        rst_i         = 1'b1;
        fetch_i       = '0;
        fetch_valid_i = 1'b0;
        ex_wr_i       = '0;
        mem_wr_i      = '0;
        wb_wr_i       = '0;
        exp_test      = '0;
        exp_pkt       = '0;
        n_rec         = 0;
        n_inst        = 0;
        loaded        = 1'b0;
        read_records(ok);
        loaded = 1'b1;
        if (!ok) begin
            $display("could not open tests/id_tests.dat");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            repeat (16) @(posedge clk);
            @(negedge clk);
            rst_i = 1'b0;
            for (int i = 0; i < n_rec; i++) begin
                if (rec_write[i]) begin
                    drive_write(i);
                end else begin
                    drive_inst(i);
                end
            end
            while (pending_cnt != 0) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);
            if (pass_cnt + fail_cnt != n_inst) begin
                $display("%0d packets never arrived", n_inst - pass_cnt - fail_cnt);
            end
            $display("summary: %0d passed, %0d failed, %0d unexpected packets, %0d ready errors",
                     pass_cnt, fail_cnt, stray_cnt, ready_err_cnt);
            if (fail_cnt == 0 && stray_cnt == 0 && ready_err_cnt == 0 &&
                pass_cnt == n_inst) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
